// File: hdl/capture_pkg.sv
// Shared definitions for the capture and replay sample buffer
// Sample and memory word widths, burst sizes and address widths
// State encodings for the packer and the replayer FSMs

`default_nettype none

package capture_pkg;

  // *************************************************************************
  // Data path widths
  // *************************************************************************

  // One converter sample on the input and on the output
  localparam int SAMPLE_WIDTH = 64;

  // Four samples share one wide memory word
  localparam int PACK_RATIO = 4;
  localparam int LANE_WIDTH = $clog2(PACK_RATIO);
  localparam int WORD_WIDTH = SAMPLE_WIDTH * PACK_RATIO;

  // *************************************************************************
  // Burst geometry
  // *************************************************************************

  // A burst always holds the same number of samples
  localparam int BURST_SAMPLES = 256;
  localparam int BURST_WORDS = BURST_SAMPLES / PACK_RATIO;

  // The wide port addresses words and the narrow port addresses samples
  localparam int WORD_ADDR_WIDTH = $clog2(BURST_WORDS);
  localparam int SAMPLE_ADDR_WIDTH = $clog2(BURST_SAMPLES);

  // *************************************************************************
  // FSM states
  // *************************************************************************

  // Packer waits for a start, then collects one burst
  typedef enum logic {
    PACK_IDLE    = 1'b0,
    PACK_CAPTURE = 1'b1
  } pack_state_t;

  // Replayer waits for a finished capture, then walks the narrow port
  typedef enum logic {
    RPL_IDLE   = 1'b0,
    RPL_REPLAY = 1'b1
  } replay_state_t;

endpackage

`default_nettype wire

// File: hdl/sample_packer.sv
// Capture side of the sample buffer
// FSM that accepts a capture request while no replay is running
// Lane counter that packs four samples into one wide memory word
// Word counter that drives the write address and flags the end of the burst

`timescale 1ns/100ps
`default_nettype none

module sample_packer import capture_pkg::*; (
  input  wire                        clka,
  input  wire                        rst,
  input  wire                        capture_start,
  input  wire                        in_valid,
  input  wire [SAMPLE_WIDTH-1:0]     in_data,
  input  wire                        replay_busy,
  output logic                       wea,
  output logic [WORD_ADDR_WIDTH-1:0] addra,
  output logic [WORD_WIDTH-1:0]      dina,
  output logic                       capture_done,
  output logic                       capture_busy
);

  pack_state_t                state;
  logic [LANE_WIDTH-1:0]      lane_cnt;
  logic [WORD_ADDR_WIDTH-1:0] word_cnt;
  logic                       take_sample;
  logic                       word_end;
  logic                       burst_end;

  // *************************************************************************
  // Acceptance
  // *************************************************************************

  // Samples count only inside CAPTURE, so the start cycle sample is dropped
  assign take_sample = (state == PACK_CAPTURE) && in_valid;

  // The fourth sample of a group completes one wide word
  assign word_end = take_sample && (lane_cnt == LANE_WIDTH'(PACK_RATIO - 1));

  // The last word of the burst ends the capture
  assign burst_end = word_end && (word_cnt == WORD_ADDR_WIDTH'(BURST_WORDS - 1));

  assign capture_busy = (state == PACK_CAPTURE);

  // *************************************************************************
  // Control
  // *************************************************************************

  always_ff @(posedge clka) begin
    // Write strobe and done flag are single-cycle pulses
    wea <= 1'b0;
    capture_done <= 1'b0;
    if (rst) begin
      state <= PACK_IDLE;
      lane_cnt <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        PACK_IDLE: begin
          // A running replay still reads the buffer, so a start waits for it
          if (capture_start && !replay_busy) begin
            state <= PACK_CAPTURE;
            lane_cnt <= '0;
            word_cnt <= '0;
          end
        end
        PACK_CAPTURE: begin
          if (take_sample) begin
            lane_cnt <= lane_cnt + 1'b1;
          end
          if (word_end) begin
            wea <= 1'b1;
            word_cnt <= word_cnt + 1'b1;
          end
          // Done rises on the same edge as the final write strobe
          if (burst_end) begin
            capture_done <= 1'b1;
            state <= PACK_IDLE;
          end
        end
        default: state <= PACK_IDLE;
      endcase
    end
  end

  // *************************************************************************
  // Packing data path
  // *************************************************************************

  // New samples enter at the top, so the first of a group ends in the lowest slice
  always_ff @(posedge clka) begin
    if (take_sample) begin
      dina <= {in_data, dina[WORD_WIDTH-1:SAMPLE_WIDTH]};
    end
    if (word_end) begin
      addra <= word_cnt;
    end
  end

  // In IDLE the only write strobe allowed is the one for the last word of a burst
  a_no_idle_write : assert property (
    @(posedge clka) disable iff (rst)
    (wea && (state == PACK_IDLE)) |-> capture_done
  ) else $error("write strobe raised in IDLE outside the end of a burst");

  // The end of a burst is always carried by a write of its last word
  a_done_with_write : assert property (
    @(posedge clka) disable iff (rst)
    capture_done |-> wea
  ) else $error("capture done without the final word write");

endmodule

`default_nettype wire

// File: hdl/mem_asym.sv
// Asymmetric single-clock buffer memory
// Write port and read port of different widths over one storage array
// Supported width ratios are 1, 2, 4 and 8 in either direction
// Read data is registered one cycle after the read address

`timescale 1ns/100ps
`default_nettype none

module mem_asym #(
  parameter int A_ADDRESS_WIDTH = 6,
  parameter int A_DATA_WIDTH    = 256,
  parameter int B_ADDRESS_WIDTH = 8,
  parameter int B_DATA_WIDTH    = 64
) (
  input  wire                       clka,
  input  wire                       wea,
  input  wire [A_ADDRESS_WIDTH-1:0] addra,
  input  wire [A_DATA_WIDTH-1:0]    dina,
  input  wire [B_ADDRESS_WIDTH-1:0] addrb,
  output logic [B_DATA_WIDTH-1:0]   doutb
);

  // The array is kept at the narrower width and the deeper address space
  localparam int WIDE_WRITE = (A_DATA_WIDTH > B_DATA_WIDTH) ? 1 : 0;
  localparam int MEM_ADDRESS_WIDTH =
    (A_ADDRESS_WIDTH > B_ADDRESS_WIDTH) ? A_ADDRESS_WIDTH : B_ADDRESS_WIDTH;
  localparam int MEM_DATA_WIDTH =
    (A_DATA_WIDTH > B_DATA_WIDTH) ? B_DATA_WIDTH : A_DATA_WIDTH;
  localparam int MEM_SIZE = 2 ** MEM_ADDRESS_WIDTH;
  localparam int MEM_RATIO = (WIDE_WRITE == 1) ?
    A_DATA_WIDTH / B_DATA_WIDTH : B_DATA_WIDTH / A_DATA_WIDTH;
  localparam int RATIO_BITS = $clog2(MEM_RATIO);

  logic [MEM_DATA_WIDTH-1:0] m_ram [0:MEM_SIZE-1];

  // Both ports must cover the same number of bits
  if ((2 ** A_ADDRESS_WIDTH) * A_DATA_WIDTH != (2 ** B_ADDRESS_WIDTH) * B_DATA_WIDTH) begin
    : g_size_check
    $error("mem_asym write and read port sizes differ");
  end

  // *************************************************************************
  // Port width conversion
  // *************************************************************************

  case (MEM_RATIO)
    1: begin : g_ratio_1
      // Equal widths need no conversion at all
      always_ff @(posedge clka) begin
        if (wea) begin
          m_ram[addra] <= dina;
        end
        doutb <= m_ram[addrb];
      end
    end
    2, 4, 8: begin : g_ratio_n
      if (WIDE_WRITE == 1) begin : g_wide_write
        // A wide word fills consecutive narrow locations, lowest slice first
        always_ff @(posedge clka) begin
          if (wea) begin
            for (int i = 0; i < MEM_RATIO; i++) begin
              m_ram[{addra, RATIO_BITS'(i)}] <= dina[i*B_DATA_WIDTH +: B_DATA_WIDTH];
            end
          end
          doutb <= m_ram[addrb];
        end
      end else begin : g_wide_read
        // A wide read gathers consecutive narrow locations, lowest slice first
        always_ff @(posedge clka) begin
          if (wea) begin
            m_ram[addra] <= dina;
          end
          for (int i = 0; i < MEM_RATIO; i++) begin
            doutb[i*A_DATA_WIDTH +: A_DATA_WIDTH] <= m_ram[{addrb, RATIO_BITS'(i)}];
          end
        end
      end
    end
    default: begin : g_ratio_bad
      $error("mem_asym supports width ratios of 1, 2, 4 and 8 only");
    end
  endcase

  // The write strobe comes from reset logic, so it is defined from the second edge on
  a_wea_known : assert property (
    @(posedge clka) ##1 !$isunknown(wea)
  ) else $error("memory write enable is unknown");

endmodule

`default_nettype wire

// File: hdl/burst_replayer.sv
// Replay side of the sample buffer
// FSM that starts on a finished capture and walks the narrow read port
// One-stage valid and last pipeline matched to the registered read data
// Busy flag that holds off new captures until the last sample has left

`timescale 1ns/100ps
`default_nettype none

module burst_replayer import capture_pkg::*; (
  input  wire                          clka,
  input  wire                          rst,
  input  wire                          capture_done,
  input  wire [SAMPLE_WIDTH-1:0]       doutb,
  output logic [SAMPLE_ADDR_WIDTH-1:0] addrb,
  output logic                         out_valid,
  output logic [SAMPLE_WIDTH-1:0]      out_data,
  output logic                         out_last,
  output logic                         replay_busy
);

  replay_state_t state;
  logic          rd_issue;
  logic          rd_final;

  // *************************************************************************
  // Read address sequencing
  // *************************************************************************

  // Every cycle in REPLAY presents one sample address to the memory
  assign rd_issue = (state == RPL_REPLAY);

  // Address 255 is the last sample of the burst
  assign rd_final = rd_issue && (addrb == SAMPLE_ADDR_WIDTH'(BURST_SAMPLES - 1));

  always_ff @(posedge clka) begin
    if (rst) begin
      state <= RPL_IDLE;
      addrb <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
      replay_busy <= 1'b0;
    end else begin
      // Strobes trail the address by one cycle, like the memory read data
      out_valid <= rd_issue;
      out_last <= rd_final;
      case (state)
        RPL_IDLE: begin
          if (capture_done) begin
            state <= RPL_REPLAY;
            addrb <= '0;
            replay_busy <= 1'b1;
          end
        end
        RPL_REPLAY: begin
          addrb <= addrb + 1'b1;
          if (rd_final) begin
            state <= RPL_IDLE;
          end
        end
        default: state <= RPL_IDLE;
      endcase
      // Busy drops on the same edge as out_valid, after the last sample
      if (out_last) begin
        replay_busy <= 1'b0;
      end
    end
  end

  // The memory output register already lines up with out_valid
  assign out_data = doutb;

  // The packer must not finish a burst while the previous one is replaying
  a_no_done_in_replay : assert property (
    @(posedge clka) disable iff (rst)
    capture_done |-> !replay_busy
  ) else $error("capture finished while a replay was still running");

  // The last marker only ever tags a valid sample
  a_last_is_valid : assert property (
    @(posedge clka) disable iff (rst)
    out_last |-> out_valid
  ) else $error("out_last raised without out_valid");

endmodule

`default_nettype wire

// File: hdl/capture_replay_top.sv
// Top level of the capture and replay sample buffer
// Packer writes a 256-sample burst as wide words into the asymmetric memory
// Replayer reads the burst back one sample per cycle

`timescale 1ns/100ps
`default_nettype none

module capture_replay_top import capture_pkg::*; (
  input  wire                     clka,
  input  wire                     rst,
  input  wire                     capture_start,
  input  wire                     in_valid,
  input  wire [SAMPLE_WIDTH-1:0]  in_data,
  output logic                    out_valid,
  output logic [SAMPLE_WIDTH-1:0] out_data,
  output logic                    out_last,
  output logic                    capture_busy,
  output logic                    replay_busy
);

  // Wide write port from the packer
  logic                       wea;
  logic [WORD_ADDR_WIDTH-1:0] addra;
  logic [WORD_WIDTH-1:0]      dina;
  logic                       capture_done;

  // Narrow read port to the replayer
  logic [SAMPLE_ADDR_WIDTH-1:0] addrb;
  logic [SAMPLE_WIDTH-1:0]      doutb;

  sample_packer i_packer (
    .clka          (clka),
    .rst           (rst),
    .capture_start (capture_start),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .replay_busy   (replay_busy),
    .wea           (wea),
    .addra         (addra),
    .dina          (dina),
    .capture_done  (capture_done),
    .capture_busy  (capture_busy)
  );

  // Wide side holds words, narrow side holds single samples
  mem_asym #(
    .A_ADDRESS_WIDTH (WORD_ADDR_WIDTH),
    .A_DATA_WIDTH    (WORD_WIDTH),
    .B_ADDRESS_WIDTH (SAMPLE_ADDR_WIDTH),
    .B_DATA_WIDTH    (SAMPLE_WIDTH)
  ) i_mem (
    .clka  (clka),
    .wea   (wea),
    .addra (addra),
    .dina  (dina),
    .addrb (addrb),
    .doutb (doutb)
  );

  burst_replayer i_replayer (
    .clka         (clka),
    .rst          (rst),
    .capture_done (capture_done),
    .doutb        (doutb),
    .addrb        (addrb),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_last     (out_last),
    .replay_busy  (replay_busy)
  );

endmodule

`default_nettype wire

// File: verif/tb_capture_replay.sv
// Testbench for the capture and replay sample buffer
// Clock, reset and LFSR stimulus with random gaps in in_valid
// Reference model of the capture rule with a queue of expected samples
// Concurrent assertions on busy flags, output timing and replayed data
// Watchdog and closing report

`timescale 1ns/100ps
`default_nettype none

module tb_capture_replay import capture_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  // Edge count after the last accepted sample on which out_last is high
  localparam int REPLAY_END = BURST_SAMPLES + 1;
  // Two bursts of up to 512 input cycles and 256 output cycles, doubled for margin
  localparam int WATCHDOG_NS = 2 * (2 * BURST_SAMPLES + BURST_SAMPLES) * CLK_PERIOD * 2;

  logic                    clka = 1'b0;
  logic                    rst;
  logic                    capture_start;
  logic                    in_valid;
  logic [SAMPLE_WIDTH-1:0] in_data;
  logic                    out_valid;
  logic [SAMPLE_WIDTH-1:0] out_data;
  logic                    out_last;
  logic                    capture_busy;
  logic                    replay_busy;

  // Reference model state
  logic [SAMPLE_WIDTH-1:0] exp_q[$];
  logic                    m_capture;
  int                      m_taken;
  int                      since_end;
  int                      bursts_captured;
  logic                    started;
  logic                    cmp_valid;
  logic                    cmp_miss;
  logic [SAMPLE_WIDTH-1:0] cmp_got;
  logic [SAMPLE_WIDTH-1:0] cmp_exp;
  logic [31:0]             lfsr = 32'h1b0e_ea6f;
  int                      errors = 0;
  int                      n_out = 0;

  capture_replay_top DUT (
    .clka          (clka),
    .rst           (rst),
    .capture_start (capture_start),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_last      (out_last),
    .capture_busy  (capture_busy),
    .replay_busy   (replay_busy)
  );

  always #(CLK_PERIOD / 2) clka = ~clka;

  // ************************************************************************
  // Random stimulus
  // ************************************************************************

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // One clock cycle of input traffic, valid about three cycles in four
  task automatic drive_cycle(input logic start);
    logic [63:0] gap;
    logic [63:0] data;
    @(posedge clka);
    take_bits(2, gap);
    take_bits(SAMPLE_WIDTH, data);
    capture_start <= start;
    in_valid <= (gap[1:0] != 2'b00);
    in_data <= data[SAMPLE_WIDTH-1:0];
  endtask

  // ************************************************************************
  // Reference model
  // ************************************************************************

  always @(posedge clka) begin
    if (rst) begin
      m_capture <= 1'b0;
      m_taken <= 0;
      since_end <= -1;
      bursts_captured <= 0;
      started <= 1'b0;
      cmp_valid <= 1'b0;
      cmp_miss <= 1'b0;
    end else begin
      // Every output sample is paired with the oldest expected sample
      cmp_valid <= out_valid;
      if (out_valid) begin
        n_out++;
        cmp_got <= out_data;
        cmp_miss <= (exp_q.size() == 0);
        if (exp_q.size() != 0) begin
          cmp_exp <= exp_q.pop_front();
        end
      end
      if (capture_start) begin
        started <= 1'b1;
      end
      // Samples count only in CAPTURE; a start is taken in IDLE with no replay running
      if (m_capture) begin
        if (in_valid) begin
          exp_q.push_back(in_data);
          m_taken <= m_taken + 1;
          if (m_taken == BURST_SAMPLES - 1) begin
            m_capture <= 1'b0;
            since_end <= 0;
            bursts_captured <= bursts_captured + 1;
          end
        end
      end else if (capture_start && !(since_end >= 1 && since_end <= REPLAY_END)) begin
        m_capture <= 1'b1;
        m_taken <= 0;
      end
      // since_end holds k after edge E+k, E being the edge of the last sample
      if (since_end == REPLAY_END) begin
        since_end <= -1;
      end else if (since_end >= 0) begin
        since_end <= since_end + 1;
      end
    end
  end

  // ************************************************************************
  // Checks
  // ************************************************************************

  a_quiet_after_reset : assert property (@(posedge clka) disable iff (rst)
    !started |-> !(out_valid || out_last || capture_busy || replay_busy))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: output active before the first capture_start", $time);
  end

  a_capture_busy : assert property (@(posedge clka) disable iff (rst)
    capture_busy == m_capture)
  else begin
    errors++;
    $display("CHECK FAILED at %0t: capture_busy is %b, expected %b", $time,
      capture_busy, m_capture);
  end

  a_replay_busy : assert property (@(posedge clka) disable iff (rst)
    replay_busy == (since_end >= 1 && since_end <= REPLAY_END))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: replay_busy is %b at step %0d", $time,
      replay_busy, since_end);
  end

  // out_valid covers edges E+2 to E+257, so exactly 256 cycles
  a_valid_window : assert property (@(posedge clka) disable iff (rst)
    out_valid == (since_end >= 2 && since_end <= REPLAY_END))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: out_valid is %b at step %0d", $time,
      out_valid, since_end);
  end

  a_last_position : assert property (@(posedge clka) disable iff (rst)
    out_last == (since_end == REPLAY_END))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: out_last is %b at step %0d", $time,
      out_last, since_end);
  end

  a_sample_expected : assert property (@(posedge clka) disable iff (rst)
    cmp_valid |-> !cmp_miss)
  else begin
    errors++;
    $display("Output sample at %0t arrived with no captured sample left to match", $time);
  end

  a_sample_data : assert property (@(posedge clka) disable iff (rst)
    (cmp_valid && !cmp_miss) |-> (cmp_got == cmp_exp))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: out_data %h, expected %h", $time, cmp_got, cmp_exp);
  end

  // ************************************************************************
  // Test sequence
  // ************************************************************************

  initial begin
    rst = 1'b1;
    capture_start = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    repeat (4) @(posedge clka);
    rst <= 1'b0;
    // Traffic before any start is dropped
    repeat (20) drive_cycle(1'b0);
    for (int b = 1; b <= 2; b++) begin
      // The start cycle's own sample is dropped as well
      drive_cycle(1'b1);
      while (bursts_captured < b) drive_cycle(1'b0);
      // A start in the middle of the replay must be ignored
      while (since_end != 20) drive_cycle(1'b0);
      drive_cycle(1'b1);
      while (since_end != -1) drive_cycle(1'b0);
      repeat (8) drive_cycle(1'b0);
    end
    @(posedge clka);
    in_valid <= 1'b0;
    repeat (3) @(posedge clka);
    assert (exp_q.size() == 0)
    else begin
      errors++;
      $display("%0d captured samples were never replayed", exp_q.size());
    end
    assert (n_out == 2 * BURST_SAMPLES)
    else begin
      errors++;
      $display("Saw %0d output samples over two bursts instead of %0d", n_out,
        2 * BURST_SAMPLES);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Ends a run that stalls
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/capture_pkg.sv
hdl/sample_packer.sv
hdl/mem_asym.sv
hdl/burst_replayer.sv
hdl/capture_replay_top.sv
verif/tb_capture_replay.sv
